// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_csr_unit
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== csr_access_ctrl.sv ====
/*
 * csr access control decodes the address, builds the read word and turns
 * the access operation into a write word and per-register write enables
 */
`timescale 1ns/1ps

module csr_access_ctrl #(
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // access port from the core
  input  logic                      csr_access_i,
  input  csr_pkg::csr_num_e         csr_addr_i,
  input  csr_pkg::csr_op_e          csr_op_i,
  input  logic [csr_pkg::XLEN-1:0]  csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0]  csr_rdata_o,
  // identification
  input  logic [3:0]                core_id_i,
  input  logic [5:0]                cluster_id_i,
  input  logic [csr_pkg::XLEN-1:0]  boot_addr_i,
  // trap register state
  input  logic                      mie_i,
  input  logic                      mpie_i,
  input  logic [csr_pkg::XLEN-1:0]  mepc_i,
  input  logic [5:0]                mcause_i,
  input  logic [csr_pkg::XLEN-1:0]  perf_rdata_i,
  // write side
  output logic [csr_pkg::XLEN-1:0]  wdata_o,
  output logic                      mstatus_we_o,
  output logic                      mepc_we_o,
  output logic                      mcause_we_o,
  output csr_pkg::perf_sel_e        perf_sel_o,
  output logic [4:0]                pccr_index_o,
  output logic                      pccr_all_o,
  output logic                      perf_we_o
);
  import csr_pkg::*;

  // misa holds C, I or E, optional M and rv32
  localparam logic [XLEN-1:0] MISA_VALUE =
      (XLEN'(1'b1)     <<  2)   // C
    | (XLEN'(RV32E)    <<  4)   // E
    | (XLEN'(!RV32E)   <<  8)   // I unless reduced base
    | (XLEN'(RV32M)    << 12)   // M
    | (XLEN'(MXL_RV32) << 30);  // mxl

  csr_addr_u       addr_u;
  logic [XLEN-1:0] rdata_int;   // named register read word
  logic [XLEN-1:0] mstatus_rd;
  logic            sel_mstatus;
  logic            sel_mepc;
  logic            sel_mcause;
  logic            csr_we;

  assign addr_u.num = csr_addr_i;

  always_comb begin
    mstatus_rd                           = '0;
    mstatus_rd[MSTATUS_MPP_LSB +: 2]     = PRIV_LVL_M;  // machine mode only
    mstatus_rd[MSTATUS_MPIE_BIT]         = mpie_i;
    mstatus_rd[MSTATUS_MIE_BIT]          = mie_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // decode and read
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_mstatus  = 1'b0;
    sel_mepc     = 1'b0;
    sel_mcause   = 1'b0;
    perf_sel_o   = PERF_SEL_NONE;
    pccr_index_o = '0;
    pccr_all_o   = 1'b0;
    rdata_int    = '0;
    if (csr_access_i) begin  // nothing decoded without an access
      if (addr_u.pccr.prefix == PCCR_PREFIX) begin
        perf_sel_o   = PERF_SEL_PCCR;
        pccr_index_o = addr_u.pccr.index;
        pccr_all_o   = (addr_u.num == CSR_PCCR_ALL);
      end else begin
        case (addr_u.num)
          CSR_MSTATUS: begin
            sel_mstatus = 1'b1;
            rdata_int   = mstatus_rd;
          end
          CSR_MEPC: begin
            sel_mepc  = 1'b1;
            rdata_int = mepc_i;
          end
          CSR_MCAUSE: begin
            sel_mcause = 1'b1;
            rdata_int  = {mcause_i[5], 26'b0, mcause_i[4:0]};  // irq flag to msb
          end
          CSR_MISA:    rdata_int = MISA_VALUE;
          CSR_MTVEC:   rdata_int = boot_addr_i;  // vector is the boot address
          CSR_MHARTID: rdata_int = {21'b0, cluster_id_i, 1'b0, core_id_i};
          CSR_TSELECT: perf_sel_o = PERF_SEL_PCER;
          CSR_TDATA1:  perf_sel_o = PERF_SEL_PCMR;
          default: ;  // unimplemented reads zero
        endcase
      end
    end
  end

  assign csr_rdata_o = (perf_sel_o != PERF_SEL_NONE) ? perf_rdata_i : rdata_int;

  //////////////////////////////////////////////////////////////////////////
  // write word and enables
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    wdata_o = csr_wdata_i;
    csr_we  = csr_access_i;
    case (csr_op_i)
      CSR_OP_SET:   wdata_o = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata_o = csr_rdata_o & ~csr_wdata_i;
      CSR_OP_WRITE: wdata_o = csr_wdata_i;
      default:      csr_we  = 1'b0;  // no-op reads only
    endcase
  end

  assign mstatus_we_o = csr_we & sel_mstatus;
  assign mepc_we_o    = csr_we & sel_mepc;
  assign mcause_we_o  = csr_we & sel_mcause;
  assign perf_we_o    = csr_we & (perf_sel_o != PERF_SEL_NONE);  // misa etc. ignore writes

  a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
    csr_access_i |-> !$isunknown(csr_op_i));

endmodule

// ==== csr_perf_counters.sv ====
/*
 * performance counter bank: qualified events, registered increment flags,
 * saturating or wrapping counters and the pcer and pcmr control registers
 */
`timescale 1ns/1ps

module csr_perf_counters #(
  parameter int NUM_COUNTERS = 11
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // write side from access control
  input  logic [csr_pkg::XLEN-1:0]  wdata_i,
  input  csr_pkg::perf_sel_e        perf_sel_i,
  input  logic [4:0]                pccr_index_i,
  input  logic                      pccr_all_i,
  input  logic                      perf_we_i,
  // core events
  input  logic                      if_valid_i,       // new instruction from IF
  input  logic                      id_valid_i,       // ID done
  input  logic                      is_compressed_i,
  input  logic                      is_decoding_i,
  input  logic                      imiss_i,          // fetch waiting
  input  logic                      pc_set_i,         // redirect
  input  logic                      jump_i,
  input  logic                      branch_i,
  input  logic                      branch_taken_i,
  input  logic                      mem_load_i,
  input  logic                      mem_store_i,
  output logic [csr_pkg::XLEN-1:0]  perf_rdata_o
);
  import csr_pkg::*;

  localparam int NUM_EVENTS = 11;

  logic [NUM_EVENTS-1:0]                  events;
  logic [NUM_COUNTERS-1:0]                cnt_evt;    // event per counter slot
  logic [NUM_COUNTERS-1:0]                inc_d, inc_q;
  logic [NUM_COUNTERS-1:0]                cnt_we;
  logic [NUM_COUNTERS-1:0][XLEN-1:0]      cnt_q, cnt_d;
  logic [NUM_COUNTERS-1:0]                pcer_q;     // per-counter enable
  logic [1:0]                             pcmr_q;     // [1] saturate, [0] global enable

  assign events[0]  = 1'b1;                  // cycles
  assign events[1]  = if_valid_i;            // instructions
  assign events[2]  = 1'b0;                  // reserved
  assign events[3]  = 1'b0;                  // reserved
  assign events[4]  = imiss_i & ~pc_set_i;   // fetch stall, not a redirect
  assign events[5]  = mem_load_i;
  assign events[6]  = mem_store_i;
  assign events[7]  = jump_i;
  assign events[8]  = branch_i;
  assign events[9]  = branch_taken_i;
  assign events[10] = id_valid_i & is_decoding_i & is_compressed_i;

  for (genvar c = 0; c < NUM_COUNTERS; c++) begin : g_evt
    if (c < NUM_EVENTS) begin : g_used
      assign cnt_evt[c] = events[c];
    end else begin : g_spare
      assign cnt_evt[c] = 1'b0;  // no source, write-only slot
    end
    assign cnt_we[c] = perf_we_i && (perf_sel_i == PERF_SEL_PCCR) &&
                       (pccr_all_i || (int'(pccr_index_i) == c));
  end

  assign inc_d = cnt_evt & pcer_q & {NUM_COUNTERS{pcmr_q[0]}};

  //////////////////////////////////////////////////////////////////////////
  // counter update
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NUM_COUNTERS; c++) begin
      cnt_d[c] = cnt_q[c];
      if (inc_q[c] && !(pcmr_q[1] && (&cnt_q[c]))) begin
        cnt_d[c] = cnt_q[c] + 1'b1;  // wraps when not saturating
      end
      if (cnt_we[c]) cnt_d[c] = wdata_i;  // write beats pending increment
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      inc_q  <= '0;
      pcer_q <= '0;
      pcmr_q <= 2'b11;  // enabled, saturating
    end else begin
      cnt_q <= cnt_d;
      inc_q <= inc_d;
      if (perf_we_i && (perf_sel_i == PERF_SEL_PCER)) pcer_q <= wdata_i[NUM_COUNTERS-1:0];
      if (perf_we_i && (perf_sel_i == PERF_SEL_PCMR)) pcmr_q <= wdata_i[1:0];
    end
  end

  // read word for current selection
  always_comb begin
    perf_rdata_o = '0;
    case (perf_sel_i)
      PERF_SEL_PCCR: begin
        if (int'(pccr_index_i) < NUM_COUNTERS) perf_rdata_o = cnt_q[pccr_index_i];
      end
      PERF_SEL_PCER: perf_rdata_o = XLEN'(pcer_q);
      PERF_SEL_PCMR: perf_rdata_o = XLEN'(pcmr_q);
      default: ;
    endcase
  end

endmodule

// ==== csr_pkg.sv ====
/*
 * csr package: shared CSR numbers, access and trap cause types,
 * the two views of a CSR address and the mstatus field positions
 */
package csr_pkg;

  localparam int XLEN = 32;  // machine word width

  //////////////////////////////////////////////////////////////////////////
  // csr numbers and address views
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MTVEC    = 12'h305,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_PCCR_ALL = 12'h79F,  // write-all alias, top of counter window
    CSR_TSELECT  = 12'h7A0,  // pcer, counter enable mask
    CSR_TDATA1   = 12'h7A1,  // pcmr, global enable + saturation
    CSR_MHARTID  = 12'hF14
  } csr_num_e;

  typedef struct packed {
    logic [6:0] prefix;  // window tag
    logic [4:0] index;   // counter number
  } pccr_addr_t;

  // same 12 bits, named register or counter slot
  typedef union packed {
    csr_num_e   num;
    pccr_addr_t pccr;
  } csr_addr_u;

  localparam logic [6:0] PCCR_PREFIX = 7'b0111100;  // 0x780..0x79f

  //////////////////////////////////////////////////////////////////////////
  // access and trap types
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // bit 5 flags an interrupt, 4:0 is the code
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_MISALIGN = 6'h00,
    EXC_CAUSE_ILLEGAL_INSN  = 6'h02,
    EXC_CAUSE_BREAKPOINT    = 6'h03,
    EXC_CAUSE_LOAD_FAULT    = 6'h05,
    EXC_CAUSE_STORE_FAULT   = 6'h07,
    EXC_CAUSE_ECALL_MMODE   = 6'h0B,
    EXC_CAUSE_IRQ_SW_M      = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M   = 6'h27,
    EXC_CAUSE_IRQ_EXT_M     = 6'h2B
  } exc_cause_e;

  typedef enum logic [1:0] {
    PERF_SEL_NONE = 2'd0,
    PERF_SEL_PCCR = 2'd1,  // one counter or all of them
    PERF_SEL_PCER = 2'd2,
    PERF_SEL_PCMR = 2'd3
  } perf_sel_e;

  // mstatus layout
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;  // mpp is 12:11

  localparam logic [1:0] PRIV_LVL_M = 2'b11;
  localparam logic [1:0] MXL_RV32   = 2'b01;

endpackage

// ==== csr_trap_regs.sv ====
/*
 * machine trap registers: mstatus enables, mepc and mcause, with trap
 * entry save and MRET restore ahead of CSR writes
 */
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  // csr writes
  input  logic [csr_pkg::XLEN-1:0]  wdata_i,
  input  logic                      mstatus_we_i,
  input  logic                      mepc_we_i,
  input  logic                      mcause_we_i,
  // trap control from the core
  input  logic [csr_pkg::XLEN-1:0]  pc_if_i,
  input  logic [csr_pkg::XLEN-1:0]  pc_id_i,
  input  logic                      csr_save_if_i,
  input  logic                      csr_save_id_i,
  input  logic                      csr_save_cause_i,
  input  csr_pkg::exc_cause_e       csr_cause_i,
  input  logic                      csr_restore_mret_i,
  // state
  output logic                      mie_o,
  output logic                      mpie_o,
  output logic [csr_pkg::XLEN-1:0]  mepc_o,
  output logic [5:0]                mcause_o
);
  import csr_pkg::*;

  logic            mie_q, mie_d;
  logic            mpie_q, mpie_d;
  logic [XLEN-1:0] mepc_q, mepc_d;
  logic [5:0]      mcause_q, mcause_d;   // {irq, code}
  logic [XLEN-1:0] exception_pc;

  // pc of the trapping stage
  always_comb begin
    if (csr_save_if_i) begin
      exception_pc = pc_if_i;
    end else if (csr_save_id_i) begin
      exception_pc = pc_id_i;
    end else begin
      exception_pc = mepc_q;  // no stage named, keep old epc
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // csr writes first, trap control overrides below
    if (mstatus_we_i) begin
      mie_d  = wdata_i[MSTATUS_MIE_BIT];
      mpie_d = wdata_i[MSTATUS_MPIE_BIT];
    end
    if (mepc_we_i) mepc_d = wdata_i;
    if (mcause_we_i) mcause_d = {wdata_i[XLEN-1], wdata_i[4:0]};

    if (csr_save_cause_i) begin
      mpie_d   = mie_q;         // stack the enable
      mie_d    = 1'b0;          // handler runs masked
      mepc_d   = exception_pc;
      mcause_d = csr_cause_i;
    end else if (csr_restore_mret_i) begin
      mie_d    = mpie_q;
      mpie_d   = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  assign mie_o    = mie_q;
  assign mpie_o   = mpie_q;
  assign mepc_o   = mepc_q;
  assign mcause_o = mcause_q;

  a_save_src: assert property (@(posedge clk) disable iff (!rst_n)
    csr_save_cause_i |-> !(csr_save_if_i && csr_save_id_i));

  // controller issues entry and return in separate cycles
  a_save_mret: assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_cause_i && csr_restore_mret_i));

endmodule

// ==== csr_unit.sv ====
/*
 * machine-mode csr unit top: access control with trap and performance
 * counter datapaths
 */
`timescale 1ns/1ps

module csr_unit #(
  parameter int NUM_COUNTERS = 11,
  parameter bit RV32E        = 1'b0,
  parameter bit RV32M        = 1'b1
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [3:0]                core_id_i,
  input  logic [5:0]                cluster_id_i,
  input  logic [csr_pkg::XLEN-1:0]  boot_addr_i,
  // csr access
  input  logic                      csr_access_i,
  input  csr_pkg::csr_num_e         csr_addr_i,
  input  csr_pkg::csr_op_e          csr_op_i,
  input  logic [csr_pkg::XLEN-1:0]  csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0]  csr_rdata_o,
  // to the controller
  output logic                      m_irq_enable_o,
  output logic [csr_pkg::XLEN-1:0]  mepc_o,
  // trap entry and return
  input  logic [csr_pkg::XLEN-1:0]  pc_if_i,
  input  logic [csr_pkg::XLEN-1:0]  pc_id_i,
  input  logic                      csr_save_if_i,
  input  logic                      csr_save_id_i,
  input  logic                      csr_save_cause_i,
  input  csr_pkg::exc_cause_e       csr_cause_i,
  input  logic                      csr_restore_mret_i,
  // performance events
  input  logic                      if_valid_i,
  input  logic                      id_valid_i,
  input  logic                      is_compressed_i,
  input  logic                      is_decoding_i,
  input  logic                      imiss_i,
  input  logic                      pc_set_i,
  input  logic                      jump_i,
  input  logic                      branch_i,
  input  logic                      branch_taken_i,
  input  logic                      mem_load_i,
  input  logic                      mem_store_i
);
  import csr_pkg::*;

  logic [XLEN-1:0] wdata;        // shared write word
  logic            mstatus_we, mepc_we, mcause_we;
  logic            mie, mpie;
  logic [5:0]      mcause;
  logic [XLEN-1:0] mepc;
  perf_sel_e       perf_sel;
  logic [4:0]      pccr_index;
  logic            pccr_all, perf_we;
  logic [XLEN-1:0] perf_rdata;

  csr_access_ctrl #(.RV32E(RV32E), .RV32M(RV32M)) u_access_ctrl (
    .clk, .rst_n, .csr_access_i, .csr_addr_i, .csr_op_i, .csr_wdata_i, .csr_rdata_o,
    .core_id_i, .cluster_id_i, .boot_addr_i,
    .mie_i(mie), .mpie_i(mpie), .mepc_i(mepc), .mcause_i(mcause), .perf_rdata_i(perf_rdata),
    .wdata_o(wdata), .mstatus_we_o(mstatus_we), .mepc_we_o(mepc_we), .mcause_we_o(mcause_we),
    .perf_sel_o(perf_sel), .pccr_index_o(pccr_index), .pccr_all_o(pccr_all),
    .perf_we_o(perf_we)
  );

  csr_trap_regs u_trap_regs (
    .clk, .rst_n, .wdata_i(wdata),
    .mstatus_we_i(mstatus_we), .mepc_we_i(mepc_we), .mcause_we_i(mcause_we),
    .pc_if_i, .pc_id_i, .csr_save_if_i, .csr_save_id_i, .csr_save_cause_i, .csr_cause_i,
    .csr_restore_mret_i,
    .mie_o(mie), .mpie_o(mpie), .mepc_o(mepc), .mcause_o(mcause)
  );

  csr_perf_counters #(.NUM_COUNTERS(NUM_COUNTERS)) u_perf_counters (
    .clk, .rst_n, .wdata_i(wdata), .perf_sel_i(perf_sel), .pccr_index_i(pccr_index),
    .pccr_all_i(pccr_all), .perf_we_i(perf_we),
    .if_valid_i, .id_valid_i, .is_compressed_i, .is_decoding_i, .imiss_i, .pc_set_i,
    .jump_i, .branch_i, .branch_taken_i, .mem_load_i, .mem_store_i,
    .perf_rdata_o(perf_rdata)
  );

  assign m_irq_enable_o = mie;   // straight from the register
  assign mepc_o         = mepc;

endmodule

// ==== tb_clk_gen.sv ====
/*
 * testbench clock and reset: free running clock, reset held low
 * for a few cycles and released on a falling edge
 */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 50,  // ns, 100 ns period
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // away from the active edge
  end

endmodule

// ==== tb_csr_checker.sv ====
/*
 * csr unit checker: shadow model, reference read function and the
 * comparison of the unit's outputs at every rising edge
 */
`timescale 1ns/1ps

module tb_csr_checker #(
  parameter int NUM_COUNTERS = 11
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [2:0]  test_id_i,
  input  logic [3:0]  core_id_i,
  input  logic [5:0]  cluster_id_i,
  input  logic [31:0] boot_addr_i,
  input  logic        csr_access_i,
  input  logic [11:0] csr_addr_i,
  input  logic [1:0]  csr_op_i,
  input  logic [31:0] csr_wdata_i,
  input  logic [31:0] pc_if_i,
  input  logic [31:0] pc_id_i,
  input  logic        csr_save_if_i,
  input  logic        csr_save_id_i,
  input  logic        csr_save_cause_i,
  input  logic [5:0]  csr_cause_i,
  input  logic        csr_restore_mret_i,
  input  logic        if_valid_i, id_valid_i, is_compressed_i, is_decoding_i,
  input  logic        imiss_i, pc_set_i, jump_i, branch_i, branch_taken_i,
  input  logic        mem_load_i, mem_store_i,
  input  logic [31:0] csr_rdata_i,     // dut outputs
  input  logic        m_irq_enable_i,
  input  logic [31:0] mepc_i,
  output int          err_cnt_o,
  output int          check_cnt_o
);

  // shadow state
  logic                    mie, mpie;
  logic [31:0]             mepc;
  logic [5:0]              mcause;     // {irq, code}
  logic [NUM_COUNTERS-1:0] pcer, inc;  // inc = registered event flags
  logic [1:0]              pcmr;
  logic [31:0]             cnt [NUM_COUNTERS];

  int         errs = 0;
  int         checks = 0;
  int         test_errs = 0;
  int         test_checks = 0;
  logic [2:0] cur_test = 3'd0;

  assign err_cnt_o   = errs;
  assign check_cnt_o = checks;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "reset_values";
      3'd2:    return "trap_reg_ops";
      3'd3:    return "read_only";
      3'd4:    return "trap_mret";
      3'd5:    return "counting";
      3'd6:    return "saturation";
      default: return "idle";
    endcase
  endfunction

  // expected read word from the shadow state
  function automatic logic [31:0] ref_read(input logic [11:0] addr);
    logic [31:0] r;
    r = 32'h0;
    if (addr[11:5] == 7'h3c) begin  // counter window
      if (int'(addr[4:0]) < NUM_COUNTERS) r = cnt[addr[4:0]];
    end else begin
      case (addr)
        12'h300: r = 32'h1800 | (32'(mpie) << 7) | (32'(mie) << 3);  // mpp = M
        12'h301: r = 32'h4000_1104;                  // rv32 imc
        12'h305: r = boot_addr_i;
        12'h341: r = mepc;
        12'h342: r = {mcause[5], 26'h0, mcause[4:0]};
        12'h7a0: r = 32'(pcer);
        12'h7a1: r = 32'(pcmr);
        12'hf14: r = {21'h0, cluster_id_i, 1'b0, core_id_i};
        default: r = 32'h0;
      endcase
    end
    return r;
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errs++;
      test_errs++;
      $display("CHECK FAILED %s %s: expected %h actual %h",
               test_name(cur_test), what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // compare pre-edge values, then step the shadow state
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    logic [31:0]             rd_exp;
    logic [31:0]             wd;
    logic                    we;
    logic                    old_mie, old_mpie;
    logic [31:0]             old_mepc;
    logic [NUM_COUNTERS-1:0] ev;
    if (test_id_i != cur_test) begin  // test boundary, report the finished one
      if (cur_test >= 3'd1 && cur_test <= 3'd6) begin
        $display("test %-13s %0d checks, %0d errors",
                 test_name(cur_test), test_checks, test_errs);
      end
      cur_test    = test_id_i;
      test_checks = 0;
      test_errs   = 0;
    end
    if (!rst_n) begin
      mie    = 1'b0;
      mpie   = 1'b0;
      mepc   = '0;
      mcause = '0;
      pcer   = '0;
      inc    = '0;
      pcmr   = 2'b11;
      for (int c = 0; c < NUM_COUNTERS; c++) cnt[c] = '0;
    end else begin
      rd_exp = ref_read(csr_addr_i);
      if (csr_access_i) compare("rdata", rd_exp, csr_rdata_i);
      compare("irq_enable", 32'(mie), 32'(m_irq_enable_i));
      compare("mepc_o", mepc, mepc_i);

      we = csr_access_i && (csr_op_i != 2'b00);
      case (csr_op_i)
        2'b10:   wd = csr_wdata_i | rd_exp;     // set
        2'b11:   wd = rd_exp & ~csr_wdata_i;    // clear
        default: wd = csr_wdata_i;
      endcase

      // counters step on last edge's flags, a write lands on top
      for (int c = 0; c < NUM_COUNTERS; c++) begin
        if (inc[c] && !(pcmr[1] && cnt[c] == '1)) cnt[c] = cnt[c] + 1;
        if (we && csr_addr_i[11:5] == 7'h3c &&
            (csr_addr_i[4:0] == 5'h1f || int'(csr_addr_i[4:0]) == c)) begin
          cnt[c] = wd;
        end
      end

      ev     = '0;
      ev[0]  = 1'b1;                     // cycles
      ev[1]  = if_valid_i;
      ev[4]  = imiss_i & ~pc_set_i;
      ev[5]  = mem_load_i;
      ev[6]  = mem_store_i;
      ev[7]  = jump_i;
      ev[8]  = branch_i;
      ev[9]  = branch_taken_i;
      ev[10] = id_valid_i & is_decoding_i & is_compressed_i;
      inc    = ev & pcer & {NUM_COUNTERS{pcmr[0]}};  // old pcer and pcmr

      if (we && csr_addr_i == 12'h7a0) pcer = wd[NUM_COUNTERS-1:0];
      if (we && csr_addr_i == 12'h7a1) pcmr = wd[1:0];

      old_mie  = mie;
      old_mpie = mpie;
      old_mepc = mepc;
      if (we && csr_addr_i == 12'h300) begin
        mie  = wd[3];
        mpie = wd[7];
      end
      if (we && csr_addr_i == 12'h341) mepc = wd;
      if (we && csr_addr_i == 12'h342) mcause = {wd[31], wd[4:0]};

      if (csr_save_cause_i) begin  // trap beats the csr write
        mpie   = old_mie;
        mie    = 1'b0;
        mepc   = csr_save_if_i ? pc_if_i : (csr_save_id_i ? pc_id_i : old_mepc);
        mcause = csr_cause_i;
      end else if (csr_restore_mret_i) begin
        mie  = old_mpie;
        mpie = 1'b1;
      end
    end
  end

endmodule

// ==== tb_csr_unit.sv ====
/*
 * csr unit testbench top with clock, DUT and checker, a test sequence
 * driven on the falling edge from an xorshift source, and a watchdog
 */
`timescale 1ns/1ps

module tb_csr_unit;
  import csr_pkg::*;

  localparam int N_REG_OPS    = 40;   // random trap register accesses
  localparam int N_EVT_CYCLES = 60;   // random event cycles
  // reset, fixed accesses of all tests, random loops, then doubled
  localparam int RUN_CYCLES   = 4 + 90 + N_REG_OPS + N_EVT_CYCLES;
  localparam int LIMIT_CYCLES = 2 * RUN_CYCLES;

  logic        clk, rst_n;
  logic [3:0]  core_id;
  logic [5:0]  cluster_id;
  logic [31:0] boot_addr;
  logic        csr_access;
  csr_num_e    csr_addr;
  csr_op_e     csr_op;
  logic [31:0] csr_wdata, csr_rdata;
  logic        m_irq_enable;
  logic [31:0] mepc;
  logic [31:0] pc_if, pc_id;
  logic        csr_save_if, csr_save_id, csr_save_cause, csr_restore_mret;
  exc_cause_e  csr_cause;
  logic        if_valid, id_valid, is_compressed, is_decoding, imiss, pc_set;
  logic        jump, branch, branch_taken, mem_load, mem_store;
  logic [2:0]  test_id;
  int          err_cnt, check_cnt;
  logic [31:0] rng = 32'h7e3d_78ba;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  csr_unit u_csr_unit (
    .clk(clk), .rst_n(rst_n),
    .core_id_i(core_id), .cluster_id_i(cluster_id), .boot_addr_i(boot_addr),
    .csr_access_i(csr_access), .csr_addr_i(csr_addr), .csr_op_i(csr_op),
    .csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata),
    .m_irq_enable_o(m_irq_enable), .mepc_o(mepc),
    .pc_if_i(pc_if), .pc_id_i(pc_id), .csr_save_if_i(csr_save_if),
    .csr_save_id_i(csr_save_id), .csr_save_cause_i(csr_save_cause),
    .csr_cause_i(csr_cause), .csr_restore_mret_i(csr_restore_mret),
    .if_valid_i(if_valid), .id_valid_i(id_valid), .is_compressed_i(is_compressed),
    .is_decoding_i(is_decoding), .imiss_i(imiss), .pc_set_i(pc_set), .jump_i(jump),
    .branch_i(branch), .branch_taken_i(branch_taken),
    .mem_load_i(mem_load), .mem_store_i(mem_store)
  );

  tb_csr_checker u_checker (
    .clk(clk), .rst_n(rst_n), .test_id_i(test_id),
    .core_id_i(core_id), .cluster_id_i(cluster_id), .boot_addr_i(boot_addr),
    .csr_access_i(csr_access), .csr_addr_i(csr_addr), .csr_op_i(csr_op),
    .csr_wdata_i(csr_wdata), .pc_if_i(pc_if), .pc_id_i(pc_id),
    .csr_save_if_i(csr_save_if), .csr_save_id_i(csr_save_id),
    .csr_save_cause_i(csr_save_cause), .csr_cause_i(csr_cause),
    .csr_restore_mret_i(csr_restore_mret),
    .if_valid_i(if_valid), .id_valid_i(id_valid), .is_compressed_i(is_compressed),
    .is_decoding_i(is_decoding), .imiss_i(imiss), .pc_set_i(pc_set), .jump_i(jump),
    .branch_i(branch), .branch_taken_i(branch_taken),
    .mem_load_i(mem_load), .mem_store_i(mem_store),
    .csr_rdata_i(csr_rdata), .m_irq_enable_i(m_irq_enable), .mepc_i(mepc),
    .err_cnt_o(err_cnt), .check_cnt_o(check_cnt)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // everything but the ids back to quiet
  task automatic clear_inputs();
    csr_access       = 1'b0;
    csr_op           = CSR_OP_NONE;
    csr_save_if      = 1'b0;
    csr_save_id      = 1'b0;
    csr_save_cause   = 1'b0;
    csr_restore_mret = 1'b0;
    {if_valid, id_valid, is_compressed, is_decoding, imiss, pc_set} = '0;
    {jump, branch, branch_taken, mem_load, mem_store} = '0;
  endtask

  task automatic start_test(input logic [2:0] id);
    @(negedge clk);
    clear_inputs();
    test_id = id;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_inputs();
    end
  endtask

  task automatic csr_cycle(input logic [11:0] addr, input csr_op_e op,
                           input logic [31:0] wdata);
    @(negedge clk);
    clear_inputs();
    csr_access = 1'b1;
    csr_addr   = csr_num_e'(addr);
    csr_op     = op;
    csr_wdata  = wdata;
  endtask

  // trap entry with a competing mepc write; the other stage gets ~pc
  task automatic trap_save(input logic from_id, input exc_cause_e cause,
                           input logic [31:0] pc, input logic [31:0] wr);
    csr_cycle(CSR_MEPC, CSR_OP_WRITE, wr);
    csr_save_cause = 1'b1;
    csr_save_if    = !from_id;
    csr_save_id    = from_id;
    pc_if          = from_id ? ~pc : pc;
    pc_id          = from_id ? pc : ~pc;
    csr_cause      = cause;
  endtask

  task automatic mret_cycle();
    @(negedge clk);
    clear_inputs();
    csr_restore_mret = 1'b1;
  endtask

  task automatic drive_events(input logic [31:0] r);
    @(negedge clk);
    clear_inputs();
    mem_load      = r[0];
    mem_store     = r[1];
    branch        = r[2];
    branch_taken  = r[2] & r[3];
    jump          = r[4];   // masked
    if_valid      = r[5];   // masked
    imiss         = r[6];
    pc_set        = r[7];
    id_valid      = r[8];
    is_decoding   = r[9];
    is_compressed = r[10];
  endtask

  task automatic read_counters();
    for (int c = 0; c < 11; c++) csr_cycle(12'h780 | 12'(c), CSR_OP_NONE, '0);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [11:0] addr;
    core_id    = 4'h5;
    cluster_id = 6'h2a;
    boot_addr  = 32'h1c00_8000;
    csr_addr   = CSR_MSTATUS;
    csr_wdata  = '0;
    pc_if      = '0;
    pc_id      = '0;
    csr_cause  = EXC_CAUSE_INSN_MISALIGN;
    test_id    = 3'd0;
    clear_inputs();
    @(posedge rst_n);

    start_test(3'd1);
    csr_cycle(CSR_MSTATUS, CSR_OP_NONE, '0);
    csr_cycle(CSR_MEPC, CSR_OP_NONE, '0);
    csr_cycle(CSR_MCAUSE, CSR_OP_NONE, '0);
    csr_cycle(CSR_TDATA1, CSR_OP_NONE, '0);
    csr_cycle(CSR_TSELECT, CSR_OP_NONE, '0);

    start_test(3'd2);
    for (int i = 0; i < N_REG_OPS; i++) begin
      rng = xorshift(rng);
      case (rng[1:0])
        2'd0:    addr = CSR_MSTATUS;
        2'd1:    addr = CSR_MEPC;
        default: addr = CSR_MCAUSE;
      endcase
      csr_cycle(addr, csr_op_e'(rng[3:2]), xorshift(rng));
      rng = xorshift(rng);
    end

    start_test(3'd3);
    for (int i = 0; i < 3; i++) begin
      addr = (i == 0) ? CSR_MISA : ((i == 1) ? CSR_MHARTID : CSR_MTVEC);
      rng  = xorshift(rng);
      csr_cycle(addr, CSR_OP_NONE, '0);
      csr_cycle(addr, CSR_OP_WRITE, rng);
      csr_cycle(addr, CSR_OP_SET, ~rng);
      csr_cycle(addr, CSR_OP_NONE, '0);
    end

    start_test(3'd4);
    csr_cycle(CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008);  // mie on
    rng = xorshift(rng);
    trap_save(1'b0, EXC_CAUSE_ILLEGAL_INSN, rng, xorshift(rng));
    csr_cycle(CSR_MEPC, CSR_OP_NONE, '0);
    csr_cycle(CSR_MCAUSE, CSR_OP_NONE, '0);
    csr_cycle(CSR_MSTATUS, CSR_OP_NONE, '0);
    mret_cycle();
    csr_cycle(CSR_MSTATUS, CSR_OP_NONE, '0);
    rng = xorshift(rng);
    trap_save(1'b1, EXC_CAUSE_IRQ_TIMER_M, rng, ~rng);  // mie still on from mret
    csr_cycle(CSR_MEPC, CSR_OP_NONE, '0);
    csr_cycle(CSR_MCAUSE, CSR_OP_NONE, '0);
    mret_cycle();
    csr_cycle(CSR_MSTATUS, CSR_OP_NONE, '0);

    start_test(3'd5);
    csr_cycle(CSR_TSELECT, CSR_OP_WRITE, 32'h0000_0160);  // load, store, branch
    for (int i = 0; i < N_EVT_CYCLES; i++) begin
      rng = xorshift(rng);
      drive_events(rng);
    end
    idle_cycles(2);
    read_counters();

    start_test(3'd6);
    csr_cycle(CSR_TSELECT, CSR_OP_WRITE, 32'h0000_0001);  // cycle counter only
    idle_cycles(1);                                        // increment now pending
    csr_cycle(CSR_PCCR_ALL, CSR_OP_WRITE, 32'hffff_ffff);
    idle_cycles(3);
    read_counters();
    csr_cycle(CSR_TDATA1, CSR_OP_WRITE, 32'h0000_0001);   // wrap mode
    idle_cycles(2);
    repeat (4) csr_cycle(12'h780, CSR_OP_NONE, '0);
    csr_cycle(CSR_TDATA1, CSR_OP_NONE, '0);

    start_test(3'd7);
    idle_cycles(2);
    $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0 && check_cnt > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: sequence did not finish within %0d cycles", LIMIT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
csr_pkg.sv
csr_access_ctrl.sv
csr_trap_regs.sv
csr_perf_counters.sv
csr_unit.sv
tb_clk_gen.sv
tb_csr_checker.sv
tb_csr_unit.sv
